//--- compile.f
+incdir+tests
hw/CorePkg.sv
hw/ReservationStation.sv
hw/AluUnit.sv
hw/ShiftUnit.sv
hw/ResultArbiter.sv
hw/ExecBackend.sv
tests/BackendTb.sv

//--- hw/AluUnit.sv
module AluUnit (
    input  logic            clk,
    input  logic            rst,
    input  logic            issueValid,
    input  CorePkg::UOpT    issueUop,
    input  logic            stall,
    input  logic            invalidate,
    input  CorePkg::SqNT    invalidateSqN,
    output logic            outValid,
    output CorePkg::ResultT outResult,
    output logic            busy
);
    import CorePkg::*;

    DataT aluOut;
    logic takeSquashed;

    always_comb begin
        case (issueUop.opcode)
            OpAdd:   aluOut = issueUop.valA + issueUop.valB;
            OpSub:   aluOut = issueUop.valA - issueUop.valB;
            OpAnd:   aluOut = issueUop.valA & issueUop.valB;
            OpOr:    aluOut = issueUop.valA | issueUop.valB;
            OpXor:   aluOut = issueUop.valA ^ issueUop.valB;
            default: aluOut = '0;
        endcase
    end

    // held result blocked by the arbiter
    assign busy = outValid && stall;

    assign takeSquashed = invalidate && isYounger(issueUop.sqN, invalidateSqN);

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (!busy) begin
            outValid <= issueValid && !takeSquashed;
        end else if (invalidate && isYounger(outResult.sqN, invalidateSqN)) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            outResult.tag <= issueUop.tagDst;
            outResult.sqN <= issueUop.sqN;
            outResult.value <= aluOut;
        end
    end

    // routing in the top level keeps shifts away from here
    noShiftOps: assert property (@(posedge clk) disable iff (rst)
        issueValid |-> !isShiftClass(issueUop.opcode));

endmodule

//--- hw/CorePkg.sv
package CorePkg;

    // physical register tag
    typedef logic [5:0] TagT;

    // sequence number, compared as a wraparound age
    typedef logic [5:0] SqNT;

    typedef logic [31:0] DataT;

    typedef enum logic [3:0] {
        OpAdd  = 4'd0,
        OpSub  = 4'd1,
        OpAnd  = 4'd2,
        OpOr   = 4'd3,
        OpXor  = 4'd4,
        OpSll  = 4'd5,
        OpSrl  = 4'd6,
        OpSra  = 4'd7,
        OpSlt  = 4'd8,
        OpSltu = 4'd9
    } OpT;

    // renamed micro-op as it travels from dispatch to issue
    // valA/valB only hold data while the matching avail flag is set
    typedef struct packed {
        OpT   opcode;
        SqNT  sqN;
        TagT  tagDst;
        logic availA;
        TagT  tagA;
        DataT valA;
        logic availB;
        TagT  tagB;
        DataT valB;
    } UOpT;

    // one result bus beat
    typedef struct packed {
        TagT  tag;
        SqNT  sqN;
        DataT value;
    } ResultT;

    // shift/compare group goes to the shift unit, the rest to the alu
    function automatic logic isShiftClass(OpT op);
        return op inside {OpSll, OpSrl, OpSra, OpSlt, OpSltu};
    endfunction

    // true when a was issued after b, modulo the 6-bit wrap
    function automatic logic isYounger(SqNT a, SqNT b);
        logic signed [5:0] diff;
        diff = a - b;
        return diff > 0;
    endfunction

endpackage

//--- hw/ExecBackend.sv
module ExecBackend #(
    parameter int QueueSize = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            uopValid,
    input  CorePkg::UOpT    uop,
    input  logic            invalidate,
    input  CorePkg::SqNT    invalidateSqN,
    output logic            full,
    output logic            resultValid,
    output CorePkg::ResultT result
);
    import CorePkg::*;

    logic toShift;
    logic aluUopValid;
    logic shiftUopValid;
    logic aluFull;
    logic shiftFull;

    logic aluIssueValid;
    UOpT aluIssueUop;
    logic aluBusy;
    logic shiftIssueValid;
    UOpT shiftIssueUop;
    logic shiftBusy;

    logic aluOutValid;
    ResultT aluOutResult;
    logic aluStall;
    logic shiftOutValid;
    ResultT shiftOutResult;
    logic shiftStall;

    // dispatch routing by opcode class
    assign toShift = isShiftClass(uop.opcode);
    assign aluUopValid = uopValid && !toShift;
    assign shiftUopValid = uopValid && toShift;
    assign full = toShift ? shiftFull : aluFull;

    ReservationStation #(.QueueSize(QueueSize)) aluStation (
        .clk(clk), .rst(rst),
        .uopValid(aluUopValid), .uop(uop),
        .resultValid(resultValid), .result(result),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .stall(aluBusy),
        .issueValid(aluIssueValid), .issueUop(aluIssueUop),
        .full(aluFull)
    );

    ReservationStation #(.QueueSize(QueueSize)) shiftStation (
        .clk(clk), .rst(rst),
        .uopValid(shiftUopValid), .uop(uop),
        .resultValid(resultValid), .result(result),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .stall(shiftBusy),
        .issueValid(shiftIssueValid), .issueUop(shiftIssueUop),
        .full(shiftFull)
    );

    AluUnit aluUnit (
        .clk(clk), .rst(rst),
        .issueValid(aluIssueValid), .issueUop(aluIssueUop),
        .stall(aluStall),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .outValid(aluOutValid), .outResult(aluOutResult),
        .busy(aluBusy)
    );

    ShiftUnit shiftUnit (
        .clk(clk), .rst(rst),
        .issueValid(shiftIssueValid), .issueUop(shiftIssueUop),
        .stall(shiftStall),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .outValid(shiftOutValid), .outResult(shiftOutResult),
        .busy(shiftBusy)
    );

    ResultArbiter arbiter (
        .clk(clk), .rst(rst),
        .aluValid(aluOutValid), .aluResult(aluOutResult),
        .shiftValid(shiftOutValid), .shiftResult(shiftOutResult),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .aluStall(aluStall), .shiftStall(shiftStall),
        .resultValid(resultValid), .result(result)
    );

endmodule

//--- hw/ReservationStation.sv
module ReservationStation #(
    parameter int QueueSize = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            uopValid,
    input  CorePkg::UOpT    uop,
    input  logic            resultValid,
    input  CorePkg::ResultT result,
    input  logic            invalidate,
    input  CorePkg::SqNT    invalidateSqN,
    input  logic            stall,
    output logic            issueValid,
    output CorePkg::UOpT    issueUop,
    output logic            full
);
    import CorePkg::*;

    localparam int IdxW = $clog2(QueueSize);

    UOpT entries [QueueSize];
    logic [QueueSize-1:0] valid;

    logic freeFound;
    logic [IdxW-1:0] freeIdx;
    logic selFound;
    logic [IdxW-1:0] selIdx;
    UOpT enqUop;

    // pick up a broadcast value for any operand still waiting on its tag
    function automatic UOpT captureResult(UOpT u, logic busValid, ResultT bus);
        UOpT r;
        r = u;
        if (busValid && !u.availA && u.tagA == bus.tag) begin
            r.availA = 1'b1;
            r.valA = bus.value;
        end
        if (busValid && !u.availB && u.tagB == bus.tag) begin
            r.availB = 1'b1;
            r.valB = bus.value;
        end
        return r;
    endfunction

    assign full = &valid;

    // producer result in the same cycle as dispatch is caught here
    assign enqUop = captureResult(uop, resultValid, result);

    // lowest free slot
    always_comb begin
        freeFound = 1'b0;
        freeIdx = '0;
        for (int i = 0; i < QueueSize; i++) begin
            if (!valid[i] && !freeFound) begin
                freeFound = 1'b1;
                freeIdx = IdxW'(i);
            end
        end
    end

    // oldest entry with both operands present
    always_comb begin
        SqNT bestSqN;
        bestSqN = '0;
        selFound = 1'b0;
        selIdx = '0;
        for (int i = 0; i < QueueSize; i++) begin
            if (valid[i] && entries[i].availA && entries[i].availB &&
                    (!selFound || isYounger(bestSqN, entries[i].sqN))) begin
                selFound = 1'b1;
                selIdx = IdxW'(i);
                bestSqN = entries[i].sqN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            issueValid <= 1'b0;
        end else if (invalidate) begin
            for (int i = 0; i < QueueSize; i++) begin
                if (valid[i] && isYounger(entries[i].sqN, invalidateSqN)) begin
                    valid[i] <= 1'b0;
                end
            end
            // unit consumed the held uop at this edge when not stalled
            if (!stall) begin
                issueValid <= 1'b0;
            end else if (isYounger(issueUop.sqN, invalidateSqN)) begin
                issueValid <= 1'b0;
            end
        end else begin
            if (!stall) begin
                issueValid <= selFound;
                if (selFound) begin
                    valid[selIdx] <= 1'b0;
                end
            end
            if (uopValid && freeFound) begin
                valid[freeIdx] <= 1'b1;
            end
        end
    end

    // wakeup runs every cycle so older results are never missed
    always_ff @(posedge clk) begin
        for (int i = 0; i < QueueSize; i++) begin
            entries[i] <= captureResult(entries[i], resultValid, result);
        end
        if (uopValid && freeFound && !invalidate) begin
            entries[freeIdx] <= enqUop;
        end
        if (!stall && selFound) begin
            issueUop <= entries[selIdx];
        end
    end

    noEnqueueWhenFull: assert property (@(posedge clk) disable iff (rst)
        uopValid |-> !full);

    issuedOperandsReady: assert property (@(posedge clk) disable iff (rst)
        issueValid |-> issueUop.availA && issueUop.availB);

endmodule

//--- hw/ResultArbiter.sv
module ResultArbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            aluValid,
    input  CorePkg::ResultT aluResult,
    input  logic            shiftValid,
    input  CorePkg::ResultT shiftResult,
    input  logic            invalidate,
    input  CorePkg::SqNT    invalidateSqN,
    output logic            aluStall,
    output logic            shiftStall,
    output logic            resultValid,
    output CorePkg::ResultT result
);
    import CorePkg::*;

    logic aluLive;
    logic shiftLive;
    logic aluWins;

    // squashed results drop out of arbitration right away
    assign aluLive = aluValid &&
        !(invalidate && isYounger(aluResult.sqN, invalidateSqN));
    assign shiftLive = shiftValid &&
        !(invalidate && isYounger(shiftResult.sqN, invalidateSqN));

    // older sqN wins, a lone live input always wins
    assign aluWins = aluLive &&
        (!shiftLive || isYounger(shiftResult.sqN, aluResult.sqN));

    assign aluStall = aluLive && !aluWins;
    assign shiftStall = shiftLive && aluWins;

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= aluLive || shiftLive;
        end
    end

    always_ff @(posedge clk) begin
        if (aluWins) begin
            result <= aluResult;
        end else begin
            result <= shiftResult;
        end
    end

    // exactly one loser per cycle at most
    oneLoser: assert property (@(posedge clk) disable iff (rst)
        !(aluStall && shiftStall));

    // a stalled unit keeps its result valid into the next cycle
    loserHeld: assert property (@(posedge clk) disable iff (rst)
        aluStall && !invalidate |=> aluValid);

endmodule

//--- hw/ShiftUnit.sv
module ShiftUnit (
    input  logic            clk,
    input  logic            rst,
    input  logic            issueValid,
    input  CorePkg::UOpT    issueUop,
    input  logic            stall,
    input  logic            invalidate,
    input  CorePkg::SqNT    invalidateSqN,
    output logic            outValid,
    output CorePkg::ResultT outResult,
    output logic            busy
);
    import CorePkg::*;

    DataT shiftOut;
    logic [4:0] shamt;

    assign shamt = issueUop.valB[4:0];

    always_comb begin
        case (issueUop.opcode)
            OpSll:   shiftOut = issueUop.valA << shamt;
            OpSrl:   shiftOut = issueUop.valA >> shamt;
            OpSra:   shiftOut = DataT'($signed(issueUop.valA) >>> shamt);
            OpSlt:   shiftOut = DataT'($signed(issueUop.valA) < $signed(issueUop.valB));
            OpSltu:  shiftOut = DataT'(issueUop.valA < issueUop.valB);
            default: shiftOut = '0;
        endcase
    end

    assign busy = outValid && stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (!busy) begin
            outValid <= issueValid &&
                !(invalidate && isYounger(issueUop.sqN, invalidateSqN));
        end else if (invalidate && isYounger(outResult.sqN, invalidateSqN)) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            outResult.tag <= issueUop.tagDst;
            outResult.sqN <= issueUop.sqN;
            outResult.value <= shiftOut;
        end
    end

    onlyShiftOps: assert property (@(posedge clk) disable iff (rst)
        issueValid |-> isShiftClass(issueUop.opcode));

endmodule

//--- tests/StimTable.svh
`ifndef STIM_TABLE_SVH
`define STIM_TABLE_SVH

// addDispatch columns: opcode, sqN, tagDst, availA, tagA, valA, availB, tagB, valB,
//   expected result, squashed, idle cycles after the row
// addInvalidate columns: invalidateSqN, idle cycles after the row
// operands waiting on a tag carry a zero value; the expected result assumes the
// producer's expected value arrives on the bus
task automatic loadTable();
    // independent add/logic and shift/compare uops
    addDispatch(OpAdd, 6'd1, 6'd1, 1, 6'd0, 32'd5, 1, 6'd0, 32'd7, 32'd12, 0, 4);
    addDispatch(OpSub, 6'd2, 6'd2, 1, 6'd0, 32'd3, 1, 6'd0, 32'd10, 32'hFFFF_FFF9, 0, 4);
    addDispatch(OpXor, 6'd3, 6'd3, 1, 6'd0, 32'hF0F0_F0F0, 1, 6'd0, 32'h0FF0_0FF0,
        32'hFF00_FF00, 0, 4);
    addDispatch(OpAnd, 6'd4, 6'd4, 1, 6'd0, 32'hFFFF_0000, 1, 6'd0, 32'h1234_5678,
        32'h1234_0000, 0, 4);
    addDispatch(OpOr, 6'd5, 6'd5, 1, 6'd0, 32'h00FF_0000, 1, 6'd0, 32'h0000_FF00,
        32'h00FF_FF00, 0, 4);
    addDispatch(OpSll, 6'd6, 6'd6, 1, 6'd0, 32'd3, 1, 6'd0, 32'd4, 32'h30, 0, 4);
    addDispatch(OpSrl, 6'd7, 6'd7, 1, 6'd0, 32'h8000_0000, 1, 6'd0, 32'd31, 32'd1, 0, 4);
    addDispatch(OpSra, 6'd8, 6'd8, 1, 6'd0, 32'h8000_0010, 1, 6'd0, 32'd4,
        32'hF800_0001, 0, 4);
    addDispatch(OpSlt, 6'd9, 6'd9, 1, 6'd0, 32'hFFFF_FFFF, 1, 6'd0, 32'd1, 32'd1, 0, 4);
    addDispatch(OpSltu, 6'd10, 6'd10, 1, 6'd0, 32'hFFFF_FFFF, 1, 6'd0, 32'd1, 32'd0, 0, 4);
    // only the low five bits of the shift amount count
    addDispatch(OpSra, 6'd11, 6'd11, 1, 6'd0, 32'hFFFF_FF00, 1, 6'd0, 32'h24,
        32'hFFFF_FFF0, 0, 4);

    // chain across the two units
    addDispatch(OpAdd, 6'd12, 6'd12, 1, 6'd0, 32'd100, 1, 6'd0, 32'd28, 32'd128, 0, 0);
    addDispatch(OpSll, 6'd13, 6'd13, 0, 6'd12, 32'd0, 1, 6'd0, 32'd3, 32'd1024, 0, 0);
    addDispatch(OpSub, 6'd14, 6'd14, 0, 6'd13, 32'd0, 1, 6'd0, 32'd24, 32'd1000, 0, 4);

    // consumer lands in the cycle its producer is on the bus
    addDispatch(OpOr, 6'd15, 6'd15, 1, 6'd0, 32'h10, 1, 6'd0, 32'h01, 32'h11, 0, 3);
    addDispatch(OpSltu, 6'd16, 6'd16, 1, 6'd0, 32'h5, 0, 6'd15, 32'd0, 32'd1, 0, 4);

    // two consumers of one tag finish together
    addDispatch(OpAdd, 6'd17, 6'd17, 1, 6'd0, 32'h40, 1, 6'd0, 32'h2, 32'h42, 0, 0);
    addDispatch(OpXor, 6'd18, 6'd18, 0, 6'd17, 32'd0, 1, 6'd0, 32'hFF, 32'hBD, 0, 0);
    addDispatch(OpSrl, 6'd19, 6'd19, 0, 6'd17, 32'd0, 1, 6'd0, 32'd1, 32'h21, 0, 4);

    // dependent burst that fills the alu station
    addDispatch(OpAdd, 6'd20, 6'd20, 1, 6'd0, 32'd1, 1, 6'd0, 32'd1, 32'd2, 0, 0);
    addDispatch(OpAdd, 6'd21, 6'd21, 0, 6'd20, 32'd0, 1, 6'd0, 32'd1, 32'd3, 0, 0);
    addDispatch(OpAdd, 6'd22, 6'd22, 0, 6'd21, 32'd0, 1, 6'd0, 32'd1, 32'd4, 0, 0);
    addDispatch(OpAdd, 6'd23, 6'd23, 0, 6'd22, 32'd0, 1, 6'd0, 32'd1, 32'd5, 0, 0);
    addDispatch(OpAdd, 6'd24, 6'd24, 0, 6'd23, 32'd0, 1, 6'd0, 32'd1, 32'd6, 0, 0);
    addDispatch(OpAdd, 6'd25, 6'd25, 0, 6'd24, 32'd0, 1, 6'd0, 32'd1, 32'd7, 0, 0);
    addDispatch(OpAdd, 6'd26, 6'd26, 0, 6'd25, 32'd0, 1, 6'd0, 32'd1, 32'd8, 0, 4);

    // two uops stuck on tags nobody produces, then squashed
    addDispatch(OpAdd, 6'd27, 6'd27, 1, 6'd0, 32'd9, 1, 6'd0, 32'd9, 32'd18, 0, 0);
    addDispatch(OpSub, 6'd28, 6'd28, 0, 6'd63, 32'd0, 1, 6'd0, 32'd1, 32'd0, 1, 0);
    addDispatch(OpSra, 6'd29, 6'd29, 0, 6'd62, 32'd0, 1, 6'd0, 32'd1, 32'd0, 1, 0);
    addInvalidate(6'd27, 4);
    addDispatch(OpSlt, 6'd30, 6'd30, 1, 6'd0, 32'h7FFF_FFFF, 1, 6'd0, 32'h8000_0000,
        32'd0, 0, 4);
endtask

`endif

//--- tests/BackendTb.sv
module BackendTb;
    import CorePkg::*;

    typedef struct {
        logic isInv;
        OpT   op;
        SqNT  sqN;
        TagT  tagDst;
        logic availA;
        TagT  tagA;
        DataT valA;
        logic availB;
        TagT  tagB;
        DataT valB;
        DataT expected;
        logic squashed;
        int   idle;
    } RowT;

    logic clk;
    logic rst;
    logic uopValid;
    UOpT uop;
    logic invalidate;
    SqNT invalidateSqN;
    logic full;
    logic resultValid;
    ResultT result;

    RowT rows[$];
    int tagRow[64];
    int seenCount[64];
    int seenTotal;
    int liveTotal;
    int fullWaits;
    int seed;

    ExecBackend #(.QueueSize(4)) DUT (
        .clk(clk), .rst(rst),
        .uopValid(uopValid), .uop(uop),
        .invalidate(invalidate), .invalidateSqN(invalidateSqN),
        .full(full), .resultValid(resultValid), .result(result)
    );

    task automatic addDispatch(OpT op, SqNT sqN, TagT tagDst, logic availA, TagT tagA,
            DataT valA, logic availB, TagT tagB, DataT valB, DataT expected,
            logic squashed, int idle);
        RowT r;
        r.isInv = 1'b0;
        r.op = op;
        r.sqN = sqN;
        r.tagDst = tagDst;
        r.availA = availA;
        r.tagA = tagA;
        r.valA = valA;
        r.availB = availB;
        r.tagB = tagB;
        r.valB = valB;
        r.expected = expected;
        r.squashed = squashed;
        r.idle = idle;
        rows.push_back(r);
    endtask

    task automatic addInvalidate(SqNT sqN, int idle);
        RowT r;
        r = '{op: OpAdd, default: '0};
        r.isInv = 1'b1;
        r.sqN = sqN;
        r.idle = idle;
        rows.push_back(r);
    endtask

    `include "StimTable.svh"

    task automatic checkEqual(logic [31:0] actual, logic [31:0] expected, string what);
        if (actual !== expected) begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic dispatchRow(RowT r);
        UOpT u;
        u.opcode = r.op;
        u.sqN = r.sqN;
        u.tagDst = r.tagDst;
        u.availA = r.availA;
        u.tagA = r.tagA;
        u.valA = r.valA;
        u.availB = r.availB;
        u.tagB = r.tagB;
        u.valB = r.valB;
        uop = u;
        // full follows the class of the uop on the port
        #1;
        while (full) begin
            fullWaits++;
            @(negedge clk);
            #1;
        end
        uopValid = 1'b1;
        @(negedge clk);
        uopValid = 1'b0;
    endtask

    task automatic invalidateRow(RowT r);
        invalidate = 1'b1;
        invalidateSqN = r.sqN;
        @(negedge clk);
        invalidate = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // result scoreboard
    always @(posedge clk) begin
        int row;
        if (!rst && resultValid) begin
            row = tagRow[result.tag];
            checkEqual(row >= 0, 1, "known result tag");
            checkEqual(rows[row].squashed, 0, "squashed uop on result bus");
            checkEqual(seenCount[result.tag], 0, "repeat result for tag");
            checkEqual(result.sqN, rows[row].sqN, "result sqN");
            checkEqual(result.value, rows[row].expected, "result value");
            seenCount[result.tag]++;
            seenTotal++;
        end
    end

    initial begin
        int extra;
        seed = 35350;
        seenTotal = 0;
        liveTotal = 0;
        fullWaits = 0;
        rst = 1'b1;
        uopValid = 1'b0;
        uop = '0;
        invalidate = 1'b0;
        invalidateSqN = '0;
        for (int i = 0; i < 64; i++) begin
            tagRow[i] = -1;
            seenCount[i] = 0;
        end
        loadTable();
        foreach (rows[i]) begin
            if (!rows[i].isInv) begin
                tagRow[rows[i].tagDst] = i;
                if (!rows[i].squashed) begin
                    liveTotal++;
                end
            end
        end

        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkEqual(resultValid, 0, "resultValid after reset");
        checkEqual(full, 0, "full after reset");

        foreach (rows[i]) begin
            if (rows[i].isInv) begin
                invalidateRow(rows[i]);
            end else begin
                dispatchRow(rows[i]);
            end
            repeat (rows[i].idle) @(negedge clk);
            // jitter only between scenarios so timed rows keep their spacing
            if (rows[i].idle >= 4) begin
                extra = $unsigned($random(seed)) % 4;
                repeat (extra) @(negedge clk);
            end
        end

        while (seenTotal < liveTotal) begin
            @(negedge clk);
        end
        // catch any late extra result
        repeat (20) @(negedge clk);
        checkEqual(seenTotal, liveTotal, "result count");
        checkEqual(fullWaits > 0, 1, "full raised by the dependent burst");
        $display("STATUS: PASS");
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        #1;
        repeat ((rows.size() * 20 + 100) * 100) #1;
        $display("watchdog expired with %0d of %0d results missing",
            liveTotal - seenTotal, liveTotal);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule
